// ==== mapview.f ====
+incdir+include
rtl/mapview_pkg.sv
rtl/pixelBus_if.sv
rtl/pixelStore.sv
rtl/apbLoader.sv
rtl/scrollCamera.sv
rtl/mapFetch.sv
rtl/spriteFetch.sv
rtl/pixelCompose.sv
rtl/mapView.sv
sim/mapView_tb.sv

// ==== Makefile ====
# Verilator build and run of the map viewer testbench

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 --top-module mapView_tb \
		-f mapview.f --Mdir obj_dir -o simv
	@out=$$(./obj_dir/simv); echo "$$out"; echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== sim/mapView_tb.sv ====
//------------------------------------------------
// map viewer testbench
// APB load and read back, scrolled and sprite pixels
// against a model memory, camera and pixel queue
//------------------------------------------------
`include "mapview_cfg.svh"

module mapView_tb import mapview_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int APB_WAIT = 400;
	localparam int PIX_WAIT = 200;

	logic Clock, Reset, pixelValid, frameTick;
	logic apbSel, apbEnable, apbWrite, apbReady, rgbValid;
	coord_t drawX, drawY;
	keycode_t keycode;
	memAddr_t apbAddr;
	pixIdx_t apbWdata, apbRdata;
	colour_t red, green, blue;

	// model state
	pixIdx_t modelMem [`MEM_DEPTH];
	int camX, camY;
	logic [23:0] expRgb [$];
	int expEdge [$];
	int edgeCount = 0;
	integer seed = 32'h44b0f608;

	mapView u_dut (.*);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	// count edges for the latency check
	always @(posedge Clock) edgeCount <= edgeCount + 1;

	task automatic stopRun(string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "stopped on first error");
	endtask

	task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual)
			stopRun($sformatf("ERR %s expected %0h actual %0h", name, expected, actual));
	endtask

	//------------------------------------------------
	// reference model
	//------------------------------------------------
	// -1, 0 or +1 from the two key bytes
	function automatic int stepFrom(keycode_t key, logic [7:0] back, logic [7:0] fwd);
		logic b, f;
		b = (key[7:0] == back) || (key[15:8] == back);
		f = (key[7:0] == fwd) || (key[15:8] == fwd);
		if (b && !f) return -1;
		if (f && !b) return 1;
		return 0;
	endfunction

	function automatic int clampPos(int v, int hi);
		if (v < 0) return 0;
		if (v > hi) return hi;
		return v;
	endfunction

	function automatic logic [23:0] expectPixel(int x, int y, keycode_t key);
		int relX, relY, row, col;
		memAddr_t addr;
		pixIdx_t idx, spr;
		logic [11:0] c;
		if (x < `WIN_X0 || x >= `WIN_X0 + `WIN_W || y < `WIN_Y0 || y >= `WIN_Y0 + `WIN_H)
			return 24'h0;
		// each map pixel covers 2x2 screen pixels
		addr = memAddr_t'(((y - `WIN_Y0) / 2 + camY) * `MAP_W + (x - `WIN_X0) / 2 + camX);
		idx = modelMem[addr];
		relX = x - (`SPR_CX - 7);
		relY = y - (`SPR_CY - 10);
		if (relX >= 0 && relX < `SPR_W && relY >= 0 && relY < `SPR_H) begin
			row = 0;
			col = 0;
			case (key[7:0])
				`KEY_A: row = `SPR_H;
				`KEY_D: begin
					col = `SPR_W;
					row = `SPR_H;
				end
				`KEY_W: col = `SPR_W;
				default: ;
			endcase
			spr = modelMem[memAddr_t'(`SPR_BASE + (relY + row) * `SHEET_W + relX + col)];
			// index 0 is see-through
			if (spr != 4'h0) idx = spr;
		end
		c = palette(idx);
		return {c[11:8], 4'h0, c[7:4], 4'h0, c[3:0], 4'h0};
	endfunction

	function automatic logic [7:0] pickKey();
		case ($unsigned($random(seed)) % 6)
			0: return `KEY_A;
			1: return `KEY_D;
			2: return `KEY_W;
			3: return `KEY_S;
			4: return 8'h00;
			default: return 8'($random(seed));
		endcase
	endfunction

	//------------------------------------------------
	// stimulus
	//------------------------------------------------
	task automatic apbTransfer(logic wr, memAddr_t addr, pixIdx_t wdata, output pixIdx_t rdata);
		int waited;
		@(posedge Clock);
		#1;
		apbSel = 1'b1;
		apbEnable = 1'b0;
		apbWrite = wr;
		apbAddr = addr;
		apbWdata = wdata;
		@(posedge Clock);
		#1;
		apbEnable = 1'b1;
		waited = 0;
		@(negedge Clock);
		while (!apbReady) begin
			waited++;
			if (waited > APB_WAIT) stopRun("APB transfer timed out, apbReady never rose");
			@(negedge Clock);
		end
		rdata = apbRdata;
		@(posedge Clock);
		#1;
		{apbSel, apbEnable, apbWrite} = 3'b000;
	endtask

	task automatic readBack(string name);
		memAddr_t addr;
		pixIdx_t rd;
		addr = memAddr_t'($random(seed));
		apbTransfer(1'b0, addr, 4'h0, rd);
		checkValue(name, 32'(modelMem[addr]), 32'(rd));
	endtask

	// one pixel strobe, result queued with its sampling edge
	task automatic sendPixel(int x, int y);
		@(posedge Clock);
		#1;
		expRgb.push_back(expectPixel(x, y, keycode));
		expEdge.push_back(edgeCount + 1);
		pixelValid = 1'b1;
		drawX = coord_t'(x);
		drawY = coord_t'(y);
		@(posedge Clock);
		#1;
		pixelValid = 1'b0;
	endtask

	task automatic drainPixels();
		int waited;
		waited = 0;
		while (expRgb.size() != 0) begin
			@(posedge Clock);
			waited++;
			if (waited > PIX_WAIT) stopRun("pixel result missing, rgbValid never came");
		end
	endtask

	// random spread around the window, or around the sprite box
	task automatic checkPixels(int n, logic nearSprite);
		repeat (n) begin
			if (nearSprite)
				sendPixel(135 + $unsigned($random(seed)) % 18, 116 + $unsigned($random(seed)) % 23);
			else
				sendPixel(60 + $unsigned($random(seed)) % 170, 60 + $unsigned($random(seed)) % 140);
			repeat ($unsigned($random(seed)) % 3) @(posedge Clock);
		end
		drainPixels();
	endtask

	task automatic holdKeys(keycode_t key, int ticks);
		repeat (ticks) begin
			@(posedge Clock);
			#1;
			keycode = key;
			frameTick = 1'b1;
			@(posedge Clock);
			#1;
			frameTick = 1'b0;
			camX = clampPos(camX + stepFrom(key, `KEY_A, `KEY_D), `CAM_X_MAX);
			camY = clampPos(camY + stepFrom(key, `KEY_W, `KEY_S), `CAM_Y_MAX);
			checkValue("camera x", 32'(camX), 32'(u_dut.camX));
			checkValue("camera y", 32'(camY), 32'(u_dut.camY));
		end
	endtask

	// every rgbValid matches the oldest queued pixel
	initial begin : rgbMonitor
		logic [23:0] want;
		int edgeWant;
		forever begin
			@(negedge Clock);
			if (!Reset && rgbValid) begin
				if (expRgb.size() == 0) begin
					stopRun("rgbValid rose with no pixel outstanding");
				end else begin
					want = expRgb.pop_front();
					edgeWant = expEdge.pop_front();
					checkValue("pixel latency", 32'(edgeWant + 4), 32'(edgeCount));
					checkValue("pixel colour", 32'(want), 32'({red, green, blue}));
				end
			end
		end
	end

	initial begin : mainFlow
		pixIdx_t d, rd;
		{pixelValid, frameTick, apbSel, apbEnable, apbWrite} = '0;
		{drawX, drawY, keycode, apbAddr, apbWdata} = '0;
		camX = 0;
		camY = 0;
		Reset = 1'b1;
		repeat (4) @(posedge Clock);
		#1;
		Reset = 1'b0;
		@(negedge Clock);
		checkValue("reset rgbValid", 32'h0, 32'(rgbValid));
		checkValue("reset apbReady", 32'h0, 32'(apbReady));

		// fill the whole memory, then random read back
		for (int a = 0; a < `MEM_DEPTH; a++) begin
			d = pixIdx_t'($random(seed));
			modelMem[a] = d;
			apbTransfer(1'b1, memAddr_t'(a), d, rd);
		end
		repeat (300) readBack("apb read back");

		// camera at home
		checkPixels(200, 1'b0);

		// both corners first, then random wandering
		holdKeys({`KEY_S, `KEY_D}, 80);
		checkPixels(40, 1'b0);
		holdKeys({`KEY_W, `KEY_A}, 80);
		checkPixels(40, 1'b0);
		repeat (12) begin
			holdKeys({pickKey(), pickKey()}, 1 + $unsigned($random(seed)) % 40);
			checkPixels(20, 1'b0);
		end

		// each facing frame over the scrolled map
		keycode = {8'h00, `KEY_A};
		checkPixels(60, 1'b1);
		keycode = {8'h00, `KEY_D};
		checkPixels(60, 1'b1);
		keycode = {8'h00, `KEY_W};
		checkPixels(60, 1'b1);
		keycode = {8'h00, 8'h2C};
		checkPixels(60, 1'b1);

		// back to back pixels with host reads squeezed in
		fork
			repeat (80) sendPixel(60 + $unsigned($random(seed)) % 170,
				60 + $unsigned($random(seed)) % 140);
			begin
				repeat (6) @(posedge Clock);
				repeat (4) readBack("apb read during stream");
			end
		join
		drainPixels();

		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== rtl/mapView.sv ====
//------------------------------------------------
// tile map viewer top
// scrolled map, centred sprite, APB loader
//------------------------------------------------
module mapView import mapview_pkg::*; (
	input logic Clock,
	input logic Reset,
	input logic pixelValid,
	input coord_t drawX,
	input coord_t drawY,
	input logic frameTick,
	input keycode_t keycode,
	input logic apbSel,
	input logic apbEnable,
	input logic apbWrite,
	input memAddr_t apbAddr,
	input pixIdx_t apbWdata,
	output logic apbReady,
	output pixIdx_t apbRdata,
	output logic rgbValid,
	output colour_t red,
	output colour_t green,
	output colour_t blue
);

	camPos_t camX, camY;
	logic pixelStage, inWindow, spriteOn;
	coord_t stageX, stageY;

	// one bus per memory peer
	pixelBus_if mapBus ();
	pixelBus_if spriteBus ();
	pixelBus_if hostBus ();

	pixelStore u_store (.Clock, .Reset, .mapBus, .spriteBus, .hostBus);

	apbLoader u_loader (
		.Clock, .Reset, .apbSel, .apbEnable, .apbWrite, .apbAddr, .apbWdata,
		.apbReady, .apbRdata, .hostBus
	);

	scrollCamera u_camera (.Clock, .Reset, .frameTick, .keycode, .camX, .camY);

	mapFetch u_mapFetch (
		.Clock, .Reset, .pixelValid, .drawX, .drawY, .camX, .camY, .mapBus,
		.pixelStage, .inWindow, .stageX, .stageY
	);

	spriteFetch u_spriteFetch (
		.Clock, .Reset, .pixelStage, .stageX, .stageY, .keycode, .spriteBus, .spriteOn
	);

	pixelCompose u_compose (
		.Clock, .Reset, .pixelStage, .inWindow, .spriteOn,
		.mapData(mapBus.readData), .spriteData(spriteBus.readData),
		.rgbValid, .red, .green, .blue
	);

endmodule

// ==== rtl/pixelCompose.sv ====
//------------------------------------------------
// pixel compose, sprite over map, palette, RGB out
//------------------------------------------------
module pixelCompose import mapview_pkg::*; (
	input logic Clock,
	input logic Reset,
	input logic pixelStage,
	input logic inWindow,
	input logic spriteOn,
	input pixIdx_t mapData,
	input pixIdx_t spriteData,
	output logic rgbValid,
	output colour_t red,
	output colour_t green,
	output colour_t blue
);

	logic s1Valid, s1Win;
	logic s2Valid, s2Win, s2Spr;
	logic s3Valid, s3Win;
	pixIdx_t s2Map, s3Idx;
	logic [11:0] rgb12;

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset) begin
			{s1Valid, s1Win} <= '0;
			{s2Valid, s2Win, s2Spr} <= '0;
			{s3Valid, s3Win} <= '0;
			rgbValid <= 1'b0;
		end else begin
			{s1Valid, s1Win} <= {pixelStage, inWindow};
			{s2Valid, s2Win, s2Spr} <= {s1Valid, s1Win, spriteOn};
			{s3Valid, s3Win} <= {s2Valid, s2Win};
			rgbValid <= s3Valid;
		end
	end

	// map index held one cycle to meet the sprite index
	// sprite index 0 lets the map through
	always_ff @(posedge Clock) begin
		s2Map <= mapData;
		s3Idx <= (s2Spr && spriteData != '0) ? spriteData : s2Map;
	end

	assign rgb12 = palette(s3Idx);

	// channel in the upper nibble, black outside window
	always_ff @(posedge Clock) begin
		red <= s3Win ? {rgb12[11:8], 4'h0} : '0;
		green <= s3Win ? {rgb12[7:4], 4'h0} : '0;
		blue <= s3Win ? {rgb12[3:0], 4'h0} : '0;
	end

endmodule

// ==== rtl/spriteFetch.sv ====
//------------------------------------------------
// sprite fetch
// box test around the screen centre, facing frame
// from the low key byte, sheet address
//------------------------------------------------
`include "mapview_cfg.svh"

module spriteFetch import mapview_pkg::*; (
	input logic Clock,
	input logic Reset,
	input logic pixelStage,
	input coord_t stageX,
	input coord_t stageY,
	input keycode_t keycode,
	pixelBus_if.peer spriteBus,
	output logic spriteOn
);

	// box corner, 7 left and 10 above the centre
	localparam coord_t BOX_X0 = coord_t'(`SPR_CX - `SPR_W / 2);
	localparam coord_t BOX_Y0 = coord_t'(`SPR_CY - (`SPR_H + 1) / 2);

	coord_t relX, relY;
	logic inBox;
	logic sprReq;
	memAddr_t colOff, rowOff, sheetAddr, sprAddr;

	// below the corner wraps high and fails the test
	assign relX = stageX - BOX_X0;
	assign relY = stageY - BOX_Y0;
	assign inBox = (relX < coord_t'(`SPR_W)) && (relY < coord_t'(`SPR_H));

	// facing frame position in the sheet
	always_comb begin
		colOff = '0;
		rowOff = '0;
		case (keycode[7:0])
			`KEY_A: rowOff = memAddr_t'(`SPR_H);
			`KEY_D: begin
				colOff = memAddr_t'(`SPR_W);
				rowOff = memAddr_t'(`SPR_H);
			end
			`KEY_W: colOff = memAddr_t'(`SPR_W);
			default: ;
		endcase
	end

	assign sheetAddr = memAddr_t'(`SPR_BASE) + (memAddr_t'(relY) + rowOff) * memAddr_t'(`SHEET_W)
		+ memAddr_t'(relX) + colOff;

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset) begin
			spriteOn <= 1'b0;
			sprReq <= 1'b0;
		end else begin
			spriteOn <= pixelStage & inBox;
			sprReq <= (pixelStage & inBox) | (sprReq & ~spriteBus.grant);
		end
	end

	always_ff @(posedge Clock) begin
		if (pixelStage & inBox)
			sprAddr <= sheetAddr;
	end

	// one cycle behind the map read, never collides
	assign spriteBus.request = sprReq;
	assign spriteBus.write = 1'b0;
	assign spriteBus.address = sprAddr;
	assign spriteBus.writeData = '0;

endmodule

// ==== rtl/mapFetch.sv ====
//------------------------------------------------
// map fetch, window test and 2x scaled map address
//------------------------------------------------
`include "mapview_cfg.svh"

module mapFetch import mapview_pkg::*; (
	input logic Clock,
	input logic Reset,
	input logic pixelValid,
	input coord_t drawX,
	input coord_t drawY,
	input camPos_t camX,
	input camPos_t camY,
	pixelBus_if.peer mapBus,
	output logic pixelStage,
	output logic inWindow,
	output coord_t stageX,
	output coord_t stageY
);

	coord_t offX, offY;
	memAddr_t mapCol, mapRow, mapAddr, addrQ;
	logic winHit;

	// window relative, wraps outside but then ignored
	assign offX = drawX - coord_t'(`WIN_X0);
	assign offY = drawY - coord_t'(`WIN_Y0);
	assign winHit = (offX < coord_t'(`WIN_W)) && (offY < coord_t'(`WIN_H));

	// halve for 2x scale, then add the camera
	assign mapCol = memAddr_t'(offX[9:1]) + memAddr_t'(camX);
	assign mapRow = memAddr_t'(offY[9:1]) + memAddr_t'(camY);
	assign mapAddr = mapRow * memAddr_t'(`MAP_W) + mapCol;

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset) begin
			pixelStage <= 1'b0;
			inWindow <= 1'b0;
		end else begin
			pixelStage <= pixelValid;
			if (pixelValid)
				inWindow <= winHit;
		end
	end

	// camera is frozen into the address here
	always_ff @(posedge Clock) begin
		if (pixelValid) begin
			stageX <= drawX;
			stageY <= drawY;
			addrQ <= mapAddr;
		end
	end

	// map read always wins, so one cycle is enough
	assign mapBus.request = pixelStage;
	assign mapBus.write = 1'b0;
	assign mapBus.address = addrQ;
	assign mapBus.writeData = '0;

	pixelGap: assert property (@(posedge Clock) disable iff (Reset)
		pixelValid |=> !pixelValid);

endmodule

// ==== rtl/scrollCamera.sv ====
//------------------------------------------------
// scroll camera
// one map pixel per frame tick from the keycode,
// clamped at the map edges
//------------------------------------------------
`include "mapview_cfg.svh"

module scrollCamera import mapview_pkg::*; (
	input logic Clock,
	input logic Reset,
	input logic frameTick,
	input keycode_t keycode,
	output camPos_t camX,
	output camPos_t camY
);

	logic goLeft, goRight, goUp, goDown;

	// key in either byte counts as held
	function automatic logic keyHeld(keycode_t keys, logic [7:0] code);
		keyHeld = (keys[7:0] == code) || (keys[15:8] == code);
	endfunction

	// opposite keys cancel, saturate at 0 and limit
	function automatic camPos_t stepAxis(camPos_t pos, logic dec, logic inc, camPos_t limit);
		stepAxis = pos;
		if (dec && !inc && pos != '0)
			stepAxis = pos - camPos_t'(1);
		else if (inc && !dec && pos < limit)
			stepAxis = pos + camPos_t'(1);
	endfunction

	assign goLeft = keyHeld(keycode, `KEY_A);
	assign goRight = keyHeld(keycode, `KEY_D);
	assign goUp = keyHeld(keycode, `KEY_W);
	assign goDown = keyHeld(keycode, `KEY_S);

	//------------------------------------------------
	// position registers
	//------------------------------------------------
	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset) begin
			camX <= '0;
			camY <= '0;
		end else if (frameTick) begin
			camX <= stepAxis(camX, goLeft, goRight, camPos_t'(`CAM_X_MAX));
			camY <= stepAxis(camY, goUp, goDown, camPos_t'(`CAM_Y_MAX));
		end
	end

endmodule

// ==== rtl/apbLoader.sv ====
//------------------------------------------------
// APB slave for the host, turns transfers into
// pixel memory writes and reads
//------------------------------------------------
module apbLoader import mapview_pkg::*; (
	input logic Clock,
	input logic Reset,
	input logic apbSel,
	input logic apbEnable,
	input logic apbWrite,
	input memAddr_t apbAddr,
	input pixIdx_t apbWdata,
	output logic apbReady,
	output pixIdx_t apbRdata,
	pixelBus_if.peer hostBus
);

	apbPhase_t state, nextState;
	logic access;
	pixIdx_t rdataQ;

	// access phase of a transfer
	assign access = apbSel & apbEnable;

	// hold the request until the arbiter lets us in
	assign hostBus.request = access & (state != DONE);
	assign hostBus.write = apbWrite;
	assign hostBus.address = apbAddr;
	assign hostBus.writeData = apbWdata;

	always_comb begin
		nextState = state;
		case (state)
			IDLE: if (access) nextState = hostBus.grant ? DONE : WAIT;
			WAIT: begin
				if (hostBus.grant)
					nextState = DONE;
				else if (!access)
					nextState = IDLE;
			end
			default: nextState = IDLE;
		endcase
	end

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset)
			state <= IDLE;
		else
			state <= nextState;
	end

	// keep the last read value after the transfer
	always_ff @(posedge Clock) begin
		if (state == DONE)
			rdataQ <= hostBus.readData;
	end

	// memory data lands the cycle after the grant
	assign apbReady = (state == DONE);
	assign apbRdata = (state == DONE) ? hostBus.readData : rdataQ;

	// enable rises only after a setup cycle
	setupFirst: assert property (@(posedge Clock) disable iff (Reset)
		$rose(apbEnable) |-> $past(apbSel) && apbSel);

endmodule

// ==== rtl/pixelStore.sv ====
//------------------------------------------------
// pixel store
// fixed-priority arbiter in front of a single-port
// memory of palette indices, registered read
//------------------------------------------------
`include "mapview_cfg.svh"

module pixelStore import mapview_pkg::*; (
	input logic Clock,
	input logic Reset,
	pixelBus_if.store mapBus,
	pixelBus_if.store spriteBus,
	pixelBus_if.store hostBus
);

	logic mapGrant, spriteGrant, hostGrant;
	logic selWrite;
	memAddr_t selAddr;
	pixIdx_t selData;
	// one-hot, which peer owns the data coming out now
	logic [2:0] lastGrant;
	pixIdx_t mem [`MEM_DEPTH];
	pixIdx_t memQ;

	//------------------------------------------------
	// arbitration
	//------------------------------------------------
	// map first, then sprite, host last
	assign mapGrant = mapBus.request;
	assign spriteGrant = spriteBus.request & ~mapBus.request;
	assign hostGrant = hostBus.request & ~mapBus.request & ~spriteBus.request;

	assign mapBus.grant = mapGrant;
	assign spriteBus.grant = spriteGrant;
	assign hostBus.grant = hostGrant;

	// steer the winner onto the memory port
	always_comb begin
		selWrite = hostBus.write;
		selAddr = hostBus.address;
		selData = hostBus.writeData;
		if (mapGrant) begin
			selWrite = mapBus.write;
			selAddr = mapBus.address;
			selData = mapBus.writeData;
		end else if (spriteGrant) begin
			selWrite = spriteBus.write;
			selAddr = spriteBus.address;
			selData = spriteBus.writeData;
		end
	end

	//------------------------------------------------
	// memory array
	//------------------------------------------------
	always_ff @(posedge Clock) begin
		if (mapGrant | spriteGrant | hostGrant) begin
			if (selWrite)
				mem[selAddr] <= selData;
			else
				memQ <= mem[selAddr];
		end
	end

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset)
			lastGrant <= '0;
		else
			lastGrant <= {hostGrant, spriteGrant, mapGrant};
	end

	// read data only to the peer granted last cycle
	assign mapBus.readData = lastGrant[0] ? memQ : '0;
	assign spriteBus.readData = lastGrant[1] ? memQ : '0;
	assign hostBus.readData = lastGrant[2] ? memQ : '0;

	// map and sprite reads never meet, so no fetch waits
	fetchApart: assert property (@(posedge Clock) disable iff (Reset)
		!(mapBus.request && spriteBus.request));

endmodule

// ==== rtl/pixelBus_if.sv ====
//------------------------------------------------
// request/grant link from one memory peer
// to the pixel store arbiter
//------------------------------------------------
interface pixelBus_if import mapview_pkg::*; ();

	logic request;
	logic write;
	memAddr_t address;
	pixIdx_t writeData;
	// grant is same-cycle, readData one cycle later
	logic grant;
	pixIdx_t readData;

	modport peer (output request, write, address, writeData, input grant, readData);
	modport store (input request, write, address, writeData, output grant, readData);

endinterface

// ==== rtl/mapview_pkg.sv ====
//------------------------------------------------
// map viewer types and the fixed 16-colour palette
//------------------------------------------------
package mapview_pkg;

	typedef logic [9:0] coord_t;
	typedef logic [7:0] camPos_t;
	typedef logic [13:0] memAddr_t;
	typedef logic [3:0] pixIdx_t;
	typedef logic [7:0] colour_t;
	// two key bytes, low byte is the most recent key
	typedef logic [15:0] keycode_t;

	typedef enum logic [1:0] {IDLE, WAIT, DONE} apbPhase_t;

	// index to {red, green, blue}, 4 bits each
	function automatic logic [11:0] palette(pixIdx_t idx);
		case (idx)
			4'h0: palette = 12'h000;
			4'h1: palette = 12'hFFF;
			4'h2: palette = 12'h4A2;
			4'h3: palette = 12'h8D5;
			4'h4: palette = 12'h262;
			4'h5: palette = 12'hC96;
			4'h6: palette = 12'hA74;
			4'h7: palette = 12'h36C;
			4'h8: palette = 12'h8BF;
			4'h9: palette = 12'h963;
			4'hA: palette = 12'hC33;
			4'hB: palette = 12'hF86;
			4'hC: palette = 12'h555;
			4'hD: palette = 12'hAAA;
			4'hE: palette = 12'hFD4;
			default: palette = 12'h202;
		endcase
	endfunction

endpackage

// ==== include/mapview_cfg.svh ====
//------------------------------------------------
// map viewer configuration
// screen window, map, sprite sheet and memory sizes
//------------------------------------------------
`ifndef MAPVIEW_CFG_SVH
`define MAPVIEW_CFG_SVH

// map window on the screen, top-left corner and size
`define WIN_X0 80
`define WIN_Y0 80
`define WIN_W 128
`define WIN_H 96

// background map in map pixels
`define MAP_W 128
`define MAP_H 96

// camera limits, map size less half the window
`define CAM_X_MAX (`MAP_W - `WIN_W / 2)
`define CAM_Y_MAX (`MAP_H - `WIN_H / 2)

// player sprite centre, frame size, sheet layout
`define SPR_CX 144
`define SPR_CY 128
`define SPR_W 14
`define SPR_H 19
`define SHEET_W 28
`define SPR_BASE 12288

// shared pixel memory
`define MEM_DEPTH 16384

// keyboard scan codes
`define KEY_A 8'h04
`define KEY_D 8'h07
`define KEY_W 8'h1A
`define KEY_S 8'h16

`endif
